// File: hw/ex_pkg.sv
/* Execution pipe shared types: functional unit, ALU and BRU opcode enums,
   front-end fault code width */
`default_nettype none

package ex_pkg;

   // Width of the front-end fault code, nonzero means exception
   localparam int FE_W = 4;

   // Functional unit that receives the instruction
   typedef enum logic [1:0] {
      FU_ALU = 2'd0,
      FU_BRU = 2'd1,
      FU_LSU = 2'd2,
      FU_EPU = 2'd3
   } ex_fu_t;

   // ALU operations
   typedef enum logic [3:0] {
      ALU_ADD   = 4'd0,
      ALU_SUB   = 4'd1,
      ALU_AND   = 4'd2,
      ALU_OR    = 4'd3,
      ALU_XOR   = 4'd4,
      ALU_SLL   = 4'd5,
      ALU_SRL   = 4'd6,
      // Arithmetic right shift
      ALU_SRA   = 4'd7,
      // Set less than, signed and unsigned
      ALU_SLT   = 4'd8,
      ALU_SLTU  = 4'd9,
      // Low half of operand2 into upper half
      ALU_MOVHI = 4'd10
   } alu_op_t;

   // Branch operations
   typedef enum logic [2:0] {
      BRU_BEQ  = 3'd0,
      BRU_BNE  = 3'd1,
      BRU_BGT  = 3'd2,
      BRU_BGTU = 3'd3,
      BRU_BLE  = 3'd4,
      BRU_BLEU = 3'd5,
      // Unconditional, pc relative, with link
      BRU_JREL = 3'd6,
      // Unconditional, register target, with link
      BRU_JREG = 3'd7
   } bru_op_t;

   // Conditional branches compare via the shared subtraction
   function automatic logic bru_is_cond(input bru_op_t op);
      logic res;
      res = (op != BRU_JREL) && (op != BRU_JREG);
      return res;
   endfunction

endpackage

`default_nettype wire

// File: hw/ex_alu.sv
/* Combinational integer ALU, add/sub and compares taken from the shared adder */
`timescale 1ns/1ps
`default_nettype none

module ex_alu
   import ex_pkg::*;
#(
   parameter int DW = 32
)
(
   input  alu_op_t         alu_op,
   input  logic [DW-1:0]   operand1,
   input  logic [DW-1:0]   operand2,
   input  logic [DW-1:0]   add_sum,
   input  logic            add_carry,
   input  logic            add_overflow,
   output logic [DW-1:0]   alu_result
);
   localparam int SHW = $clog2(DW);
   localparam int HW  = DW / 2;

   logic [SHW-1:0] shamt;
   logic           lt_signed;
   logic           lt_unsigned;
   logic [DW-1:0]  shl_res;
   logic [DW-1:0]  shr_res;
   logic [DW-1:0]  sra_res;

   assign shamt = operand2[SHW-1:0];

   // Adder does operand1 - operand2 for compares
   assign lt_signed   = add_sum[DW-1] ^ add_overflow;
   // No carry out means a borrow happened
   assign lt_unsigned = ~add_carry;

   assign shl_res = operand1 << shamt;
   assign shr_res = operand1 >> shamt;
   assign sra_res = $signed(operand1) >>> shamt;

   always_comb begin
      case (alu_op)
         ALU_ADD,
         ALU_SUB: begin
            alu_result = add_sum;
         end
         ALU_AND: begin
            alu_result = operand1 & operand2;
         end
         ALU_OR: begin
            alu_result = operand1 | operand2;
         end
         ALU_XOR: begin
            alu_result = operand1 ^ operand2;
         end
         ALU_SLL: begin
            alu_result = shl_res;
         end
         ALU_SRL: begin
            alu_result = shr_res;
         end
         ALU_SRA: begin
            alu_result = sra_res;
         end
         ALU_SLT: begin
            alu_result = {{DW-1{1'b0}}, lt_signed};
         end
         ALU_SLTU: begin
            alu_result = {{DW-1{1'b0}}, lt_unsigned};
         end
         ALU_MOVHI: begin
            alu_result = {operand2[HW-1:0], {DW-HW{1'b0}}};
         end
         default: begin
            alu_result = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: hw/ex_bru.sv
/* Branch unit: condition evaluation from the shared subtraction,
   target computation and link value */
`timescale 1ns/1ps
`default_nettype none

module ex_bru
   import ex_pkg::*;
#(
   parameter int DW   = 32,
   parameter int PC_W = 30
)
(
   input  logic            is_bru,
   input  bru_op_t         bru_op,
   input  logic [PC_W-1:0] pc,
   input  logic [PC_W-1:0] npc,
   input  logic [DW-1:0]   imm,
   input  logic [DW-1:0]   operand1,
   input  logic [DW-1:0]   add_sum,
   input  logic            add_carry,
   input  logic            add_overflow,
   output logic            b_taken,
   output logic [PC_W-1:0] b_tgt,
   output logic [DW-1:0]   link_dout,
   output logic            link_valid
);
   logic            cmp_eq;
   logic            cmp_gt;
   logic            cmp_gtu;
   logic            cond;
   logic            is_jump;
   logic [PC_W-1:0] rel_tgt;

   // Flags of operand1 - operand2
   assign cmp_eq  = (add_sum == '0);
   assign cmp_gt  = ~(add_sum[DW-1] ^ add_overflow) & ~cmp_eq;
   assign cmp_gtu = add_carry & ~cmp_eq;

   always_comb begin
      case (bru_op)
         BRU_BEQ: begin
            cond = cmp_eq;
         end
         BRU_BNE: begin
            cond = ~cmp_eq;
         end
         BRU_BGT: begin
            cond = cmp_gt;
         end
         BRU_BGTU: begin
            cond = cmp_gtu;
         end
         BRU_BLE: begin
            cond = ~cmp_gt;
         end
         BRU_BLEU: begin
            cond = ~cmp_gtu;
         end
         default: begin
            // JREL and JREG always go
            cond = 1'b1;
         end
      endcase
   end

   assign is_jump = ~bru_is_cond(bru_op);

   // Separate adder for pc relative targets, imm counts words
   assign rel_tgt = pc + imm[PC_W-1:0];

   assign b_tgt = (bru_op == BRU_JREG) ? operand1[PC_W-1:0] : rel_tgt;

   assign b_taken = is_bru & cond;

   // Return address for the link register
   assign link_valid = is_bru & is_jump;
   assign link_dout  = {{DW-PC_W{1'b0}}, npc};

endmodule

`default_nettype wire

// File: hw/ex_hds_buf.sv
/* One-entry valid/ready stage control with flush */
`timescale 1ns/1ps
`default_nettype none

module ex_hds_buf (
   input  logic clk,
   input  logic arst_n,
   input  logic flush,
   input  logic a_valid,
   output logic a_ready,
   output logic b_valid,
   input  logic b_ready,
   output logic p_ce
);
   logic occ_q;

   // Accept when empty or when the held entry leaves this cycle
   assign a_ready = ~occ_q | b_ready;
   assign p_ce    = a_valid & a_ready;
   assign b_valid = occ_q;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         occ_q <= 1'b0;
      end else if (flush) begin
         // Drops both the held entry and one accepted now
         occ_q <= 1'b0;
      end else if (p_ce) begin
         occ_q <= 1'b1;
      end else if (b_ready) begin
         occ_q <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// File: hw/ex_pipe.sv
/* Integer execution pipe top level: shared adder, AGU select,
   misprediction check and the registered writeback stage */
`timescale 1ns/1ps
`default_nettype none

module ex_pipe
   import ex_pkg::*;
#(
   parameter int DW     = 32,
   parameter int PC_W   = 30,
   parameter int ROB_AW = 4,
   parameter int PRF_AW = 6
)
(
   input  logic              clk,
   input  logic              arst_n,
   input  logic              flush,
   input  logic              ex_valid,
   input  ex_fu_t            ex_fu,
   input  alu_op_t           ex_alu_op,
   input  bru_op_t           ex_bru_op,
   input  logic [FE_W-1:0]   ex_fe,
   input  logic              ex_pred_taken,
   input  logic [PC_W-1:0]   ex_pred_tgt,
   input  logic [PC_W-1:0]   ex_pc,
   input  logic [DW-1:0]     ex_imm,
   input  logic [DW-1:0]     ex_operand1,
   input  logic [DW-1:0]     ex_operand2,
   input  logic [PRF_AW-1:0] ex_prd,
   input  logic              ex_prd_we,
   input  logic [ROB_AW-1:0] ex_rob_id,
   output logic              ex_ready,
   input  logic              wb_ready,
   output logic              wb_valid,
   output logic [ROB_AW-1:0] wb_rob_id,
   output logic              prf_we,
   output logic [PRF_AW-1:0] prf_waddr,
   output logic [DW-1:0]     prf_wdata,
   output logic              wb_fls,
   output logic              wb_exc,
   output logic [DW-1:0]     wb_opera,
   output logic [DW-1:0]     wb_operb
);
   logic            p_ce;
   logic            is_alu;
   logic            is_bru;
   logic            agu_en;
   logic            add_s;
   logic [DW-1:0]   add_b;
   logic [DW-1:0]   add_b_inv;
   logic [DW-1:0]   add_sum;
   logic            add_carry;
   logic            add_overflow;
   logic [PC_W-1:0] npc;
   logic [DW-1:0]   alu_result;
   logic            b_taken;
   logic [PC_W-1:0] b_tgt;
   logic [DW-1:0]   link_dout;
   logic            link_valid;
   logic            se_fail;
   logic [PC_W-1:0] fls_tgt;
   logic            s1_exc;
   logic            s1_prf_we;
   logic [DW-1:0]   s1_rf_dout;
   logic [DW-1:0]   s1_opera;
   logic            prf_we_q;

   assign is_alu = (ex_fu == FU_ALU);
   assign is_bru = (ex_fu == FU_BRU);
   // LSU and EPU only need an address, operand1 + imm
   assign agu_en = (ex_fu == FU_LSU) | (ex_fu == FU_EPU);

   // Subtract for compares and conditional branches
   assign add_s = (is_alu & ((ex_alu_op == ALU_SUB) |
                             (ex_alu_op == ALU_SLT) |
                             (ex_alu_op == ALU_SLTU))) |
                  (is_bru & bru_is_cond(ex_bru_op));

   // Shared adder
   assign add_b     = agu_en ? ex_imm : ex_operand2;
   assign add_b_inv = add_s ? ~add_b : add_b;
   assign {add_carry, add_sum} = {1'b0, ex_operand1} + {1'b0, add_b_inv} + {{DW{1'b0}}, add_s};
   assign add_overflow = (ex_operand1[DW-1] == add_b_inv[DW-1]) &
                         (add_sum[DW-1] != ex_operand1[DW-1]);

   assign npc = ex_pc + {{PC_W-1{1'b0}}, 1'b1};

   ex_alu #(
      .DW           (DW)
   ) alu_inst (
      .alu_op       (ex_alu_op),
      .operand1     (ex_operand1),
      .operand2     (ex_operand2),
      .add_sum      (add_sum),
      .add_carry    (add_carry),
      .add_overflow (add_overflow),
      .alu_result   (alu_result)
   );

   ex_bru #(
      .DW           (DW),
      .PC_W         (PC_W)
   ) bru_inst (
      .is_bru       (is_bru),
      .bru_op       (ex_bru_op),
      .pc           (ex_pc),
      .npc          (npc),
      .imm          (ex_imm),
      .operand1     (ex_operand1),
      .add_sum      (add_sum),
      .add_carry    (add_carry),
      .add_overflow (add_overflow),
      .b_taken      (b_taken),
      .b_tgt        (b_tgt),
      .link_dout    (link_dout),
      .link_valid   (link_valid)
   );

   // Target only matters when both sides say taken
   assign se_fail = (b_taken ^ ex_pred_taken) |
                    (b_taken & ex_pred_taken & (b_tgt != ex_pred_tgt));
   assign fls_tgt = b_taken ? b_tgt : npc;
   assign s1_exc  = |ex_fe;

   // Flush target wins over fault code, then address
   assign s1_opera = se_fail ? {{DW-PC_W{1'b0}}, fls_tgt} :
                     s1_exc  ? {{DW-FE_W{1'b0}}, ex_fe} :
                               add_sum;

   assign s1_rf_dout = link_valid ? link_dout : alu_result;
   assign s1_prf_we  = (is_alu | is_bru) & ex_prd_we;

   ex_hds_buf hds_buf_inst (
      .clk     (clk),
      .arst_n  (arst_n),
      .flush   (flush),
      .a_valid (ex_valid),
      .a_ready (ex_ready),
      .b_valid (wb_valid),
      .b_ready (wb_ready),
      .p_ce    (p_ce)
   );

   // Control flags of the output stage
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         prf_we_q <= 1'b0;
         wb_fls   <= 1'b0;
         wb_exc   <= 1'b0;
      end else if (flush) begin
         prf_we_q <= 1'b0;
         wb_fls   <= 1'b0;
         wb_exc   <= 1'b0;
      end else if (p_ce) begin
         prf_we_q <= s1_prf_we;
         wb_fls   <= se_fail;
         wb_exc   <= s1_exc;
      end else if (wb_ready) begin
         // Result leaves with no successor
         prf_we_q <= 1'b0;
      end
   end

   // Payload
   always_ff @(posedge clk) begin
      if (p_ce) begin
         wb_rob_id <= ex_rob_id;
         prf_waddr <= ex_prd;
         prf_wdata <= s1_rf_dout;
         wb_opera  <= s1_opera;
         wb_operb  <= ex_operand2;
      end
   end

   assign prf_we = prf_we_q;

endmodule

`default_nettype wire

// File: tests/tb_clk_gen.sv
/* Testbench clock and reset generator */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
   parameter int PERIOD_NS  = 100,
   parameter int RST_CYCLES = 2
)
(
   output logic clk,
   output logic arst_n
);
   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // Reset released on a falling edge
   initial begin
      arst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
   end

endmodule

`default_nettype wire

// File: tests/ex_pipe_chk.sv
/* Bound assertions on the writeback handshake, flush and PRF write enable */
`timescale 1ns/1ps
`default_nettype none

module ex_pipe_chk #(
   parameter int DW     = 32,
   parameter int ROB_AW = 4,
   parameter int PRF_AW = 6
)
(
   input logic              clk,
   input logic              arst_n,
   input logic              flush,
   input logic              ex_ready,
   input logic              wb_ready,
   input logic              wb_valid,
   input logic              prf_we,
   input logic              wb_fls,
   input logic              wb_exc,
   input logic [ROB_AW-1:0] wb_rob_id,
   input logic [PRF_AW-1:0] prf_waddr,
   input logic [DW-1:0]     prf_wdata,
   input logic [DW-1:0]     wb_opera,
   input logic [DW-1:0]     wb_operb
);
   // Number of failed assertions
   int fail_cnt = 0;

   // PRF write only with a valid result
   we_needs_valid: assert property (@(posedge clk) disable iff (!arst_n)
      prf_we |-> wb_valid)
      else begin
         $error("prf_we high while wb_valid is low");
         fail_cnt++;
      end

   // Waiting result holds until taken
   hold_while_stalled: assert property (@(posedge clk) disable iff (!arst_n)
      wb_valid && !wb_ready && !flush |=> wb_valid && $stable(wb_rob_id) &&
      $stable(prf_we) && $stable(prf_waddr) && $stable(prf_wdata) &&
      $stable(wb_fls) && $stable(wb_exc) && $stable(wb_opera) && $stable(wb_operb))
      else begin
         $error("writeback output changed while stalled");
         fail_cnt++;
      end

   no_accept_when_full: assert property (@(posedge clk) disable iff (!arst_n)
      wb_valid && !wb_ready |-> !ex_ready)
      else begin
         $error("ex_ready high while the stage is stalled");
         fail_cnt++;
      end

   flush_empties: assert property (@(posedge clk) disable iff (!arst_n)
      flush |=> !wb_valid)
      else begin
         $error("wb_valid high in the cycle after flush");
         fail_cnt++;
      end

endmodule

bind ex_pipe ex_pipe_chk #(
   .DW     (DW),
   .ROB_AW (ROB_AW),
   .PRF_AW (PRF_AW)
) chk_inst (
   .clk (clk), .arst_n (arst_n), .flush (flush), .ex_ready (ex_ready),
   .wb_ready (wb_ready), .wb_valid (wb_valid), .prf_we (prf_we),
   .wb_fls (wb_fls), .wb_exc (wb_exc), .wb_rob_id (wb_rob_id),
   .prf_waddr (prf_waddr), .prf_wdata (prf_wdata),
   .wb_opera (wb_opera), .wb_operb (wb_operb)
);

`default_nettype wire

// File: tests/ex_pipe_tb.sv
/* Directed testbench for the execution pipe: reference model, compare tasks,
   watchdog and closing status */
`timescale 1ns/1ps
`default_nettype none

module ex_pipe_tb
   import ex_pkg::*;
;
   localparam int DW        = 32;
   localparam int PC_W      = 30;
   localparam int ROB_AW    = 4;
   localparam int PRF_AW    = 6;
   localparam int PERIOD_NS = 100;
   // 300 transactions of at most 4 cycles each
   localparam int TIMEOUT_NS = 300 * 4 * PERIOD_NS;

   logic              clk;
   logic              arst_n;
   logic              flush;
   logic              ex_valid;
   logic              ex_ready;
   logic              wb_ready;
   logic              wb_valid;
   ex_fu_t            ex_fu;
   alu_op_t           ex_alu_op;
   bru_op_t           ex_bru_op;
   logic [FE_W-1:0]   ex_fe;
   logic              ex_pred_taken;
   logic [PC_W-1:0]   ex_pred_tgt;
   logic [PC_W-1:0]   ex_pc;
   logic [DW-1:0]     ex_imm;
   logic [DW-1:0]     ex_operand1;
   logic [DW-1:0]     ex_operand2;
   logic [PRF_AW-1:0] ex_prd;
   logic              ex_prd_we;
   logic [ROB_AW-1:0] ex_rob_id;
   logic [ROB_AW-1:0] wb_rob_id;
   logic              prf_we;
   logic [PRF_AW-1:0] prf_waddr;
   logic [DW-1:0]     prf_wdata;
   logic              wb_fls;
   logic              wb_exc;
   logic [DW-1:0]     wb_opera;
   logic [DW-1:0]     wb_operb;
   integer            seed = 65;
   int                err_cnt = 0;

   tb_clk_gen #(.PERIOD_NS(PERIOD_NS)) clk_gen_inst (.clk(clk), .arst_n(arst_n));

   ex_pipe #(
      .DW     (DW),
      .PC_W   (PC_W),
      .ROB_AW (ROB_AW),
      .PRF_AW (PRF_AW)
   ) ex_pipe_inst (.*);

   task automatic chk_word(input string what, input logic [DW-1:0] got,
                           input logic [DW-1:0] exp);
      if (got !== exp) begin
         $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
         err_cnt++;
      end
   endtask

   task automatic chk_bit(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
         err_cnt++;
      end
   endtask

   task automatic chk_rob(input string what, input logic [ROB_AW-1:0] got,
                          input logic [ROB_AW-1:0] exp);
      if (got !== exp) begin
         $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
         err_cnt++;
      end
   endtask

   function automatic logic [DW-1:0] alu_ref(input alu_op_t op, input logic [DW-1:0] a,
                                             input logic [DW-1:0] b);
      logic [DW-1:0] r;
      case (op)
         ALU_ADD:   r = a + b;
         ALU_SUB:   r = a - b;
         ALU_AND:   r = a & b;
         ALU_OR:    r = a | b;
         ALU_XOR:   r = a ^ b;
         ALU_SLL:   r = a << b[4:0];
         ALU_SRL:   r = a >> b[4:0];
         ALU_SRA:   r = $signed(a) >>> b[4:0];
         ALU_SLT:   r = DW'($signed(a) < $signed(b));
         ALU_SLTU:  r = DW'(a < b);
         ALU_MOVHI: r = {b[DW/2-1:0], {DW/2{1'b0}}};
         default:   r = '0;
      endcase
      return r;
   endfunction

   function automatic logic branch_taken(input bru_op_t op, input logic [DW-1:0] a,
                                         input logic [DW-1:0] b);
      logic t;
      case (op)
         BRU_BEQ:  t = (a == b);
         BRU_BNE:  t = (a != b);
         BRU_BGT:  t = ($signed(a) > $signed(b));
         BRU_BGTU: t = (a > b);
         BRU_BLE:  t = ($signed(a) <= $signed(b));
         BRU_BLEU: t = (a <= b);
         default:  t = 1'b1;
      endcase
      return t;
   endfunction

   // Payload inputs back to a plain ALU add
   task automatic idle_inputs();
      ex_fu         = FU_ALU;
      ex_alu_op     = ALU_ADD;
      ex_bru_op     = BRU_BEQ;
      ex_fe         = '0;
      ex_pred_taken = 1'b0;
      ex_pred_tgt   = '0;
      ex_pc         = '0;
      ex_imm        = '0;
      ex_operand1   = '0;
      ex_operand2   = '0;
      ex_prd        = '0;
      ex_prd_we     = 1'b0;
      ex_rob_id     = '0;
   endtask

   // Called on a falling edge, returns on the falling edge after the transfer
   task automatic issue();
      ex_valid = 1'b1;
      #1;
      while (!ex_ready) begin
         @(negedge clk);
         #1;
      end
      @(posedge clk);
      @(negedge clk);
      ex_valid = 1'b0;
   endtask

   // Called right after issue, so the result is due now
   task automatic await_result();
      int n;
      n = 0;
      while (!wb_valid && n < 8) begin
         @(negedge clk);
         n++;
      end
      if (!wb_valid) begin
         $display("No result reached writeback within 8 cycles at %0t", $time);
         err_cnt++;
      end else if (n != 0) begin
         $display("Result reached writeback %0d cycles late at %0t", n, $time);
         err_cnt++;
      end
   endtask

   task automatic alu_sweep();
      logic [DW-1:0] a;
      logic [DW-1:0] b;
      for (int r = 0; r < 2; r++) begin
         for (int i = 0; i <= 10; i++) begin
            a = $random(seed);
            b = $random(seed);
            idle_inputs();
            ex_alu_op   = alu_op_t'(i);
            ex_operand1 = a;
            ex_operand2 = b;
            ex_prd      = PRF_AW'($random(seed));
            ex_prd_we   = $random(seed) & 1;
            ex_rob_id   = ROB_AW'(i);
            issue();
            await_result();
            chk_word("alu prf_wdata", prf_wdata, alu_ref(alu_op_t'(i), a, b));
            chk_bit("alu prf_we", prf_we, ex_prd_we);
            chk_word("alu prf_waddr", DW'(prf_waddr), DW'(ex_prd));
            chk_rob("alu wb_rob_id", wb_rob_id, ROB_AW'(i));
            chk_bit("alu wb_fls", wb_fls, 1'b0);
            chk_bit("alu wb_exc", wb_exc, 1'b0);
         end
      end
   endtask

   task automatic branch_sweep();
      logic [DW-1:0]   a;
      logic [DW-1:0]   b;
      logic [PC_W-1:0] pc;
      logic [PC_W-1:0] npc_exp;
      logic [PC_W-1:0] tgt;
      logic [PC_W-1:0] ptgt;
      logic            taken;
      logic            ptaken;
      logic            fls;
      for (int i = 0; i < 8; i++) begin
         for (int k = 0; k < 4; k++) begin
            idle_inputs();
            a       = $random(seed);
            b       = k[0] ? a : $random(seed);
            pc      = PC_W'($random(seed));
            npc_exp = pc + 1'b1;
            ex_imm  = $random(seed);
            taken   = branch_taken(bru_op_t'(i), a, b);
            tgt     = (i == BRU_JREG) ? a[PC_W-1:0] : pc + ex_imm[PC_W-1:0];
            // Correct, inverted, taken with a wrong target,
            // and correct direction with a wrong target
            ptaken = (k == 1) ? ~taken : ((k == 2) ? 1'b1 : taken);
            ptgt   = (k >= 2) ? tgt + 1'b1 : tgt;
            fls    = (taken != ptaken) || (taken && ptaken && tgt != ptgt);
            ex_fu         = FU_BRU;
            ex_bru_op     = bru_op_t'(i);
            ex_pc         = pc;
            ex_operand1   = a;
            ex_operand2   = b;
            ex_pred_taken = ptaken;
            ex_pred_tgt   = ptgt;
            ex_prd_we     = 1'b1;
            ex_rob_id     = ROB_AW'(k);
            issue();
            await_result();
            chk_bit("bru wb_fls", wb_fls, fls);
            chk_bit("bru prf_we", prf_we, 1'b1);
            if (fls) begin
               chk_word("bru flush target", wb_opera, DW'(taken ? tgt : npc_exp));
            end
            if (i >= 6) begin
               chk_word("jump link", prf_wdata, DW'(npc_exp));
            end
         end
      end
   endtask

   task automatic agu_pass();
      for (int i = 2; i < 4; i++) begin
         idle_inputs();
         ex_fu       = ex_fu_t'(i);
         ex_operand1 = $random(seed);
         ex_operand2 = $random(seed);
         ex_imm      = $random(seed);
         ex_prd_we   = 1'b1;
         issue();
         await_result();
         chk_bit("agu prf_we", prf_we, 1'b0);
         chk_word("agu wb_opera", wb_opera, ex_operand1 + ex_imm);
         chk_word("agu wb_operb", wb_operb, ex_operand2);
      end
   endtask

   task automatic exception_cases();
      logic [PC_W-1:0] tgt;
      idle_inputs();
      ex_alu_op   = ALU_XOR;
      ex_operand1 = $random(seed);
      ex_fe       = 4'h5;
      issue();
      await_result();
      chk_bit("fault wb_exc", wb_exc, 1'b1);
      chk_word("fault code", wb_opera, DW'(4'h5));
      // Mispredicted jump with a fault, flush target wins
      ex_fu     = FU_BRU;
      ex_bru_op = BRU_JREL;
      ex_pc     = PC_W'($random(seed));
      ex_imm    = $random(seed);
      ex_fe     = 4'hc;
      tgt       = ex_pc + ex_imm[PC_W-1:0];
      issue();
      await_result();
      chk_bit("fault+flush wb_exc", wb_exc, 1'b1);
      chk_bit("fault+flush wb_fls", wb_fls, 1'b1);
      chk_word("fault+flush target", wb_opera, DW'(tgt));
   endtask

   task automatic backpressure_case();
      logic [DW-1:0] first;
      // Let the previous result leave first
      @(negedge clk);
      idle_inputs();
      ex_operand1 = $random(seed);
      ex_operand2 = $random(seed);
      ex_rob_id   = 4'h1;
      first       = ex_operand1 + ex_operand2;
      wb_ready    = 1'b0;
      issue();
      ex_operand1 = $random(seed);
      ex_rob_id   = 4'h2;
      ex_valid    = 1'b1;
      repeat (3) begin
         @(negedge clk);
         chk_bit("stalled wb_valid", wb_valid, 1'b1);
         chk_bit("stalled ex_ready", ex_ready, 1'b0);
         chk_rob("stalled wb_rob_id", wb_rob_id, 4'h1);
         chk_word("stalled prf_wdata", prf_wdata, first);
      end
      wb_ready = 1'b1;
      @(negedge clk);
      ex_valid = 1'b0;
      chk_bit("second wb_valid", wb_valid, 1'b1);
      chk_rob("second wb_rob_id", wb_rob_id, 4'h2);
      chk_word("second prf_wdata", prf_wdata, ex_operand1 + ex_operand2);
      @(negedge clk);
      chk_bit("drained wb_valid", wb_valid, 1'b0);
   endtask

   task automatic flush_case();
      idle_inputs();
      ex_rob_id = 4'h3;
      wb_ready  = 1'b0;
      issue();
      flush = 1'b1;
      @(negedge clk);
      flush = 1'b0;
      chk_bit("flushed wb_valid", wb_valid, 1'b0);
      // Flush in the same cycle as an accept
      wb_ready  = 1'b1;
      ex_rob_id = 4'h4;
      ex_valid  = 1'b1;
      flush     = 1'b1;
      @(negedge clk);
      ex_valid = 1'b0;
      flush    = 1'b0;
      chk_bit("flush on accept wb_valid", wb_valid, 1'b0);
      @(negedge clk);
      chk_bit("after flush wb_valid", wb_valid, 1'b0);
   endtask

   initial begin
      #(TIMEOUT_NS);
      $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
      $display("STATUS: FAIL");
      $finish;
   end

   initial begin
      idle_inputs();
      flush    = 1'b0;
      ex_valid = 1'b0;
      wb_ready = 1'b1;
      wait (arst_n === 1'b1);
      @(negedge clk);
      chk_bit("reset wb_valid", wb_valid, 1'b0);
      chk_bit("reset prf_we", prf_we, 1'b0);
      chk_bit("reset wb_fls", wb_fls, 1'b0);
      chk_bit("reset wb_exc", wb_exc, 1'b0);
      alu_sweep();
      branch_sweep();
      agu_pass();
      exception_cases();
      backpressure_case();
      flush_case();
      $display("Tests done, %0d compare errors, %0d assertion failures", err_cnt,
               ex_pipe_inst.chk_inst.fail_cnt);
      if (err_cnt == 0 && ex_pipe_inst.chk_inst.fail_cnt == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: ex_pipe.f
hw/ex_pkg.sv
hw/ex_alu.sv
hw/ex_bru.sv
hw/ex_hds_buf.sv
hw/ex_pipe.sv
tests/tb_clk_gen.sv
tests/ex_pipe_chk.sv
tests/ex_pipe_tb.sv
